// File: verilog/idu_pkg.sv
package idu_pkg;

    localparam int XLEN              = 32;
    localparam int OPCODE_WIDTH      = 7;
    localparam int FUNCT3_WIDTH      = 3;
    localparam int FUNCT7_WIDTH      = 7;
    localparam int REG_ADDR_WIDTH    = 5;
    localparam int INST_TYPE_WIDTH   = 3;
    localparam int ALU_FUNCT_WIDTH   = 5;
    localparam int MEM_MASK_WIDTH    = 4;
    localparam int QUEUE_DEPTH       = 4;
    localparam int OPCODE_NUMBER_MAX = 10;

    // queue pointer and occupancy sizing
    localparam int QUEUE_PTR_WIDTH = $clog2(QUEUE_DEPTH);
    localparam int QUEUE_CNT_WIDTH = $clog2(QUEUE_DEPTH + 1);
    localparam logic [QUEUE_PTR_WIDTH-1:0] QUEUE_PTR_LAST = QUEUE_PTR_WIDTH'(QUEUE_DEPTH - 1);
    localparam logic [QUEUE_CNT_WIDTH-1:0] QUEUE_CNT_FULL = QUEUE_CNT_WIDTH'(QUEUE_DEPTH);

    // rv32i major opcodes
    localparam logic [OPCODE_WIDTH-1:0] OP_LUI    = 7'b0110111;
    localparam logic [OPCODE_WIDTH-1:0] OP_AUIPC  = 7'b0010111;
    localparam logic [OPCODE_WIDTH-1:0] OP_JAL    = 7'b1101111;
    localparam logic [OPCODE_WIDTH-1:0] OP_JALR   = 7'b1100111;
    localparam logic [OPCODE_WIDTH-1:0] OP_BRANCH = 7'b1100011;
    localparam logic [OPCODE_WIDTH-1:0] OP_LOAD   = 7'b0000011;
    localparam logic [OPCODE_WIDTH-1:0] OP_STORE  = 7'b0100011;
    localparam logic [OPCODE_WIDTH-1:0] OP_IMM    = 7'b0010011;
    localparam logic [OPCODE_WIDTH-1:0] OP_REG    = 7'b0110011;
    localparam logic [OPCODE_WIDTH-1:0] OP_SYSTEM = 7'b1110011;

    // instruction formats, N marks an unknown opcode
    localparam logic [INST_TYPE_WIDTH-1:0] TYPE_R = 3'd0;
    localparam logic [INST_TYPE_WIDTH-1:0] TYPE_I = 3'd1;
    localparam logic [INST_TYPE_WIDTH-1:0] TYPE_S = 3'd2;
    localparam logic [INST_TYPE_WIDTH-1:0] TYPE_B = 3'd3;
    localparam logic [INST_TYPE_WIDTH-1:0] TYPE_U = 3'd4;
    localparam logic [INST_TYPE_WIDTH-1:0] TYPE_J = 3'd5;
    localparam logic [INST_TYPE_WIDTH-1:0] TYPE_N = 3'd6;

    // arithmetic codes are {0, alt, funct3}
    localparam logic [ALU_FUNCT_WIDTH-1:0] ADD  = 5'b00000;
    localparam logic [ALU_FUNCT_WIDTH-1:0] SUB  = 5'b01000;
    localparam logic [ALU_FUNCT_WIDTH-1:0] SLL  = 5'b00001;
    localparam logic [ALU_FUNCT_WIDTH-1:0] SLT  = 5'b01010;
    localparam logic [ALU_FUNCT_WIDTH-1:0] SLTU = 5'b01011;
    localparam logic [ALU_FUNCT_WIDTH-1:0] XOR  = 5'b00100;
    localparam logic [ALU_FUNCT_WIDTH-1:0] SRL  = 5'b00101;
    localparam logic [ALU_FUNCT_WIDTH-1:0] SRA  = 5'b01101;
    localparam logic [ALU_FUNCT_WIDTH-1:0] OR   = 5'b00110;
    localparam logic [ALU_FUNCT_WIDTH-1:0] AND  = 5'b00111;

    // compare codes are {2'b10, funct3}
    localparam logic [ALU_FUNCT_WIDTH-1:0] EQ  = 5'b10000;
    localparam logic [ALU_FUNCT_WIDTH-1:0] NE  = 5'b10001;
    localparam logic [ALU_FUNCT_WIDTH-1:0] LT  = 5'b10100;
    localparam logic [ALU_FUNCT_WIDTH-1:0] GE  = 5'b10101;
    localparam logic [ALU_FUNCT_WIDTH-1:0] LTU = 5'b10110;
    localparam logic [ALU_FUNCT_WIDTH-1:0] GEU = 5'b10111;

    localparam logic [ALU_FUNCT_WIDTH-1:0] NO_FUNCT = 5'b11111;

    localparam logic [MEM_MASK_WIDTH-1:0] MASK_BYTE = 4'b0001;
    localparam logic [MEM_MASK_WIDTH-1:0] MASK_HALF = 4'b0011;
    localparam logic [MEM_MASK_WIDTH-1:0] MASK_WORD = 4'b1111;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] inst;
    } fetch_pkt_t;

    typedef struct packed {
        logic                       is_branch;
        logic                       is_jal;
        logic                       is_jalr;
        logic                       gpr_w_en;
        logic                       alu_b_is_imm;
        logic [ALU_FUNCT_WIDTH-1:0] alu_funct;
        logic                       mem_r_en;
        logic                       mem_w_en;
        logic [MEM_MASK_WIDTH-1:0]  mem_mask;
        logic                       rd_is_mem;
        logic                       is_lui;
        logic                       is_auipc;
    } ctrl_t;

    typedef struct packed {
        logic [XLEN-1:0]            pc;
        logic [REG_ADDR_WIDTH-1:0]  rs1;
        logic [REG_ADDR_WIDTH-1:0]  rs2;
        logic [REG_ADDR_WIDTH-1:0]  rd;
        logic [XLEN-1:0]            imm;
        logic [INST_TYPE_WIDTH-1:0] inst_type;
        ctrl_t                      ctrl;
    } dec_pkt_t;

endpackage

// File: verilog/mux_def.sv
`timescale 1ns/10ps

module mux_def #(
    parameter int NR_KEY   = 2,
    parameter int KEY_LEN  = 1,
    parameter int DATA_LEN = 1
) (
    input  logic [KEY_LEN-1:0]                   key,
    input  logic [DATA_LEN-1:0]                  default_out,
    input  logic [NR_KEY*(KEY_LEN+DATA_LEN)-1:0] lut,
    output logic [DATA_LEN-1:0]                  out
);

    logic hit;

    // lut is a list of {key, value} pairs, the first pair sits in the top bits
    always_comb begin
        hit = 1'b0;
        out = default_out;
        for (int i = 0; i < NR_KEY; i++) begin
            if (!hit && lut[(NR_KEY-i)*(KEY_LEN+DATA_LEN)-1 -: KEY_LEN] == key) begin
                // first match wins
                hit = 1'b1;
                out = lut[(NR_KEY-i)*(KEY_LEN+DATA_LEN)-KEY_LEN-1 -: DATA_LEN];
            end
        end
    end

endmodule

// File: verilog/inst_type_dec.sv
`timescale 1ns/10ps

module inst_type_dec (
    input  logic [idu_pkg::OPCODE_WIDTH-1:0]    opcode,
    output logic [idu_pkg::INST_TYPE_WIDTH-1:0] inst_type
);

    always_comb begin
        case (opcode)
            idu_pkg::OP_REG: begin
                inst_type = idu_pkg::TYPE_R;
            end
            idu_pkg::OP_IMM,
            idu_pkg::OP_LOAD,
            idu_pkg::OP_JALR,
            idu_pkg::OP_SYSTEM: begin
                // system words carry an I-format csr/imm field
                inst_type = idu_pkg::TYPE_I;
            end
            idu_pkg::OP_STORE: begin
                inst_type = idu_pkg::TYPE_S;
            end
            idu_pkg::OP_BRANCH: begin
                inst_type = idu_pkg::TYPE_B;
            end
            idu_pkg::OP_LUI,
            idu_pkg::OP_AUIPC: begin
                inst_type = idu_pkg::TYPE_U;
            end
            idu_pkg::OP_JAL: begin
                inst_type = idu_pkg::TYPE_J;
            end
            default: begin
                inst_type = idu_pkg::TYPE_N;
            end
        endcase
    end

endmodule

// File: verilog/imm_gen.sv
`timescale 1ns/10ps

module imm_gen (
    input  logic [idu_pkg::XLEN-1:0]            inst,
    input  logic [idu_pkg::INST_TYPE_WIDTH-1:0] inst_type,
    output logic [idu_pkg::XLEN-1:0]            imm
);

    logic sign;

    assign sign = inst[31];

    always_comb begin
        case (inst_type)
            idu_pkg::TYPE_I: begin
                imm = {{20{sign}}, inst[31:20]};
            end
            idu_pkg::TYPE_S: begin
                imm = {{20{sign}}, inst[31:25], inst[11:7]};
            end
            idu_pkg::TYPE_B: begin
                // branch offsets are halfword aligned
                imm = {{19{sign}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            idu_pkg::TYPE_U: begin
                imm = {inst[31:12], 12'b0};
            end
            idu_pkg::TYPE_J: begin
                imm = {{11{sign}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            default: begin
                // r and unknown formats have no immediate
                imm = '0;
            end
        endcase
    end

endmodule

// File: verilog/ctrl.sv
`timescale 1ns/10ps

module ctrl (
    input  logic [idu_pkg::INST_TYPE_WIDTH-1:0] inst_type,
    input  logic [idu_pkg::OPCODE_WIDTH-1:0]    opcode,
    input  logic [idu_pkg::FUNCT3_WIDTH-1:0]    funct3,
    input  logic [idu_pkg::FUNCT7_WIDTH-1:0]    funct7,
    output idu_pkg::ctrl_t                      ctrl
);

    logic                                 is_slt;
    logic                                 alt_imm;
    logic                                 alt_reg;
    logic [idu_pkg::ALU_FUNCT_WIDTH-1:0]  alu_funct_branch;
    logic [idu_pkg::ALU_FUNCT_WIDTH-1:0]  alu_funct_imm;
    logic [idu_pkg::ALU_FUNCT_WIDTH-1:0]  alu_funct_reg;
    logic [idu_pkg::ALU_FUNCT_WIDTH-1:0]  alu_funct;

    // slt and sltu always use the alternate encoding
    assign is_slt = (funct3 == 3'b010) || (funct3 == 3'b011);

    // for immediates only the shifts look at funct7
    assign alt_imm = (funct3 == 3'b101) ? funct7[5] : is_slt;
    assign alt_reg = is_slt || funct7[5];

    assign alu_funct_imm = {1'b0, alt_imm, funct3};
    assign alu_funct_reg = {1'b0, alt_reg, funct3};

    mux_def #(
        .NR_KEY  (6),
        .KEY_LEN (idu_pkg::FUNCT3_WIDTH),
        .DATA_LEN(idu_pkg::ALU_FUNCT_WIDTH)
    ) mux_branch_i (
        .key        (funct3),
        .default_out(idu_pkg::NO_FUNCT),
        .lut        ({
            3'b000, idu_pkg::EQ,
            3'b001, idu_pkg::NE,
            3'b100, idu_pkg::LT,
            3'b101, idu_pkg::GE,
            3'b110, idu_pkg::LTU,
            3'b111, idu_pkg::GEU
        }),
        .out        (alu_funct_branch)
    );

    mux_def #(
        .NR_KEY  (idu_pkg::OPCODE_NUMBER_MAX),
        .KEY_LEN (idu_pkg::OPCODE_WIDTH),
        .DATA_LEN(idu_pkg::ALU_FUNCT_WIDTH)
    ) mux_alu_i (
        .key        (opcode),
        .default_out(idu_pkg::NO_FUNCT),
        .lut        ({
            idu_pkg::OP_LUI,    idu_pkg::NO_FUNCT,
            idu_pkg::OP_AUIPC,  idu_pkg::NO_FUNCT,
            idu_pkg::OP_JAL,    idu_pkg::NO_FUNCT,
            idu_pkg::OP_JALR,   idu_pkg::ADD,
            idu_pkg::OP_BRANCH, alu_funct_branch,
            idu_pkg::OP_LOAD,   idu_pkg::ADD,
            idu_pkg::OP_STORE,  idu_pkg::ADD,
            idu_pkg::OP_IMM,    alu_funct_imm,
            idu_pkg::OP_REG,    alu_funct_reg,
            idu_pkg::OP_SYSTEM, idu_pkg::NO_FUNCT
        }),
        .out        (alu_funct)
    );

    assign ctrl.is_branch    = opcode == idu_pkg::OP_BRANCH;
    assign ctrl.is_jal       = opcode == idu_pkg::OP_JAL;
    assign ctrl.is_jalr      = opcode == idu_pkg::OP_JALR;
    assign ctrl.gpr_w_en     = inst_type inside {idu_pkg::TYPE_R, idu_pkg::TYPE_I,
                                                 idu_pkg::TYPE_U, idu_pkg::TYPE_J};
    assign ctrl.alu_b_is_imm = inst_type inside {idu_pkg::TYPE_I, idu_pkg::TYPE_S};
    assign ctrl.alu_funct    = alu_funct;
    assign ctrl.mem_r_en     = opcode == idu_pkg::OP_LOAD;
    assign ctrl.mem_w_en     = opcode == idu_pkg::OP_STORE;
    // width field of loads and stores, sign bit ignored
    assign ctrl.mem_mask     = (funct3[1:0] == 2'b00) ? idu_pkg::MASK_BYTE :
                               (funct3[1:0] == 2'b01) ? idu_pkg::MASK_HALF :
                                                        idu_pkg::MASK_WORD;
    assign ctrl.rd_is_mem    = opcode == idu_pkg::OP_LOAD;
    assign ctrl.is_lui       = opcode == idu_pkg::OP_LUI;
    assign ctrl.is_auipc     = opcode == idu_pkg::OP_AUIPC;

endmodule

// File: verilog/inst_queue.sv
`timescale 1ns/10ps

module inst_queue (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                push,
    input  idu_pkg::fetch_pkt_t din,
    input  logic                pop,
    output idu_pkg::fetch_pkt_t head,
    output logic                empty,
    output logic                full
);

    idu_pkg::fetch_pkt_t                  mem [idu_pkg::QUEUE_DEPTH];
    logic [idu_pkg::QUEUE_PTR_WIDTH-1:0]  wr_ptr;
    logic [idu_pkg::QUEUE_PTR_WIDTH-1:0]  rd_ptr;
    logic [idu_pkg::QUEUE_CNT_WIDTH-1:0]  count;
    logic                                 do_push;
    logic                                 do_pop;

    assign empty = count == '0;
    assign full  = count == idu_pkg::QUEUE_CNT_FULL;

    // a full queue still takes a push when the head leaves in the same cycle
    assign do_pop  = pop && !empty;
    assign do_push = push && (!full || do_pop);

    assign head = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == idu_pkg::QUEUE_PTR_LAST) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == idu_pkg::QUEUE_PTR_LAST) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: verilog/idu.sv
`timescale 1ns/10ps

module idu (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                inst_valid,
    input  idu_pkg::fetch_pkt_t fetch,
    output logic                queue_full,
    input  logic                dec_stall,
    output logic                dec_valid,
    output idu_pkg::dec_pkt_t   dec
);

    idu_pkg::fetch_pkt_t                  head;
    logic                                 empty;
    logic                                 pop;
    logic [idu_pkg::OPCODE_WIDTH-1:0]     opcode;
    logic [idu_pkg::FUNCT3_WIDTH-1:0]     funct3;
    logic [idu_pkg::FUNCT7_WIDTH-1:0]     funct7;
    logic [idu_pkg::INST_TYPE_WIDTH-1:0]  inst_type;
    logic [idu_pkg::XLEN-1:0]             imm;
    idu_pkg::ctrl_t                       ctrl_bundle;
    idu_pkg::dec_pkt_t                    dec_d;

    inst_queue queue_i (
        .clk   (clk),
        .arst_n(arst_n),
        .push  (inst_valid),
        .din   (fetch),
        .pop   (pop),
        .head  (head),
        .empty (empty),
        .full  (queue_full)
    );

    // the head word is consumed whenever the stage downstream can take it
    assign pop = !empty && !dec_stall;

    assign opcode = head.inst[6:0];
    assign funct3 = head.inst[14:12];
    assign funct7 = head.inst[31:25];

    inst_type_dec inst_type_dec_i (
        .opcode   (opcode),
        .inst_type(inst_type)
    );

    imm_gen imm_gen_i (
        .inst     (head.inst),
        .inst_type(inst_type),
        .imm      (imm)
    );

    ctrl ctrl_i (
        .inst_type(inst_type),
        .opcode   (opcode),
        .funct3   (funct3),
        .funct7   (funct7),
        .ctrl     (ctrl_bundle)
    );

    assign dec_d = '{
        pc:        head.pc,
        rs1:       head.inst[19:15],
        rs2:       head.inst[24:20],
        rd:        head.inst[11:7],
        imm:       imm,
        inst_type: inst_type,
        ctrl:      ctrl_bundle
    };

    always_ff @(posedge clk) begin
        if (pop) begin
            dec <= dec_d;
        end
    end

    // one pulse per decoded word, low during a stall
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= pop;
        end
    end

endmodule

// File: test/idu_tb.sv
`timescale 1ns/10ps

module idu_tb;

    localparam int WAIT_LIMIT = 50;

    logic                clk;
    logic                arst_n;
    logic                inst_valid;
    idu_pkg::fetch_pkt_t fetch;
    logic                queue_full;
    logic                dec_stall;
    logic                dec_valid;
    idu_pkg::dec_pkt_t   dec;

    int                  errors;
    logic [31:0]         rng_state;
    idu_pkg::fetch_pkt_t stim_q [$];
    idu_pkg::dec_pkt_t   exp_q [$];

    idu idu_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .inst_valid(inst_valid),
        .fetch     (fetch),
        .queue_full(queue_full),
        .dec_stall (dec_stall),
        .dec_valid (dec_valid),
        .dec       (dec)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        rng_state = x;
        return x;
    endfunction

    // expected decode built from the RV32I field rules
    function automatic idu_pkg::dec_pkt_t expect_decode(input idu_pkg::fetch_pkt_t f);
        idu_pkg::dec_pkt_t d;
        logic [31:0]       w;
        logic [6:0]        op;
        logic [2:0]        f3;
        logic              slt;
        w   = f.inst;
        op  = w[6:0];
        f3  = w[14:12];
        slt = (f3 == 3'b010) || (f3 == 3'b011);
        d = '0;
        d.pc  = f.pc;
        d.rs1 = w[19:15];
        d.rs2 = w[24:20];
        d.rd  = w[11:7];
        d.inst_type      = idu_pkg::TYPE_I;
        d.ctrl.alu_funct = idu_pkg::ADD;
        case (op)
            idu_pkg::OP_REG: begin
                d.inst_type      = idu_pkg::TYPE_R;
                d.ctrl.alu_funct = {1'b0, w[30] || slt, f3};
            end
            idu_pkg::OP_IMM: begin
                d.ctrl.alu_funct = {1'b0, (f3 == 3'b101) ? w[30] : slt, f3};
            end
            idu_pkg::OP_LOAD: begin
                d.ctrl.mem_r_en  = 1'b1;
                d.ctrl.rd_is_mem = 1'b1;
            end
            idu_pkg::OP_JALR: d.ctrl.is_jalr = 1'b1;
            idu_pkg::OP_SYSTEM: d.ctrl.alu_funct = idu_pkg::NO_FUNCT;
            idu_pkg::OP_STORE: begin
                d.inst_type     = idu_pkg::TYPE_S;
                d.ctrl.mem_w_en = 1'b1;
            end
            idu_pkg::OP_BRANCH: begin
                d.inst_type      = idu_pkg::TYPE_B;
                d.ctrl.is_branch = 1'b1;
                d.ctrl.alu_funct = slt ? idu_pkg::NO_FUNCT : {2'b10, f3};
            end
            idu_pkg::OP_LUI, idu_pkg::OP_AUIPC: begin
                d.inst_type      = idu_pkg::TYPE_U;
                d.ctrl.is_lui    = op == idu_pkg::OP_LUI;
                d.ctrl.is_auipc  = op == idu_pkg::OP_AUIPC;
                d.ctrl.alu_funct = idu_pkg::NO_FUNCT;
            end
            idu_pkg::OP_JAL: begin
                d.inst_type      = idu_pkg::TYPE_J;
                d.ctrl.is_jal    = 1'b1;
                d.ctrl.alu_funct = idu_pkg::NO_FUNCT;
            end
            default: begin
                d.inst_type      = idu_pkg::TYPE_N;
                d.ctrl.alu_funct = idu_pkg::NO_FUNCT;
            end
        endcase
        d.ctrl.gpr_w_en = d.inst_type inside {idu_pkg::TYPE_R, idu_pkg::TYPE_I,
                                              idu_pkg::TYPE_U, idu_pkg::TYPE_J};
        d.ctrl.alu_b_is_imm = d.inst_type inside {idu_pkg::TYPE_I, idu_pkg::TYPE_S};
        d.ctrl.mem_mask = (f3[1:0] == 2'b00) ? 4'b0001 : (f3[1:0] == 2'b01) ? 4'b0011 : 4'b1111;
        case (d.inst_type)
            idu_pkg::TYPE_I: d.imm = {{20{w[31]}}, w[31:20]};
            idu_pkg::TYPE_S: d.imm = {{20{w[31]}}, w[31:25], w[11:7]};
            idu_pkg::TYPE_B: d.imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            idu_pkg::TYPE_U: d.imm = {w[31:12], 12'h000};
            idu_pkg::TYPE_J: d.imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            default:         d.imm = '0;
        endcase
        return d;
    endfunction

    task automatic check_value(input string name, input string what,
                               input logic [99:0] expected, input logic [99:0] actual);
        assert (actual === expected) else begin
            errors++;
            $display("mismatch %s %s expected %h actual %h", name, what, expected, actual);
        end
    endtask

    // random register numbers, opcode and function fields as given
    task automatic queue_word(input logic [6:0] op, input logic [2:0] f3, input logic [6:0] f7);
        logic [31:0] r;
        logic [31:0] pc;
        r  = next_random();
        pc = next_random();
        stim_q.push_back('{pc: {pc[31:2], 2'b00}, inst: {f7, r[24:15], f3, r[11:7], op}});
    endtask

    task automatic push_word(input idu_pkg::fetch_pkt_t f);
        int waited;
        waited = 0;
        while (queue_full && waited < WAIT_LIMIT) begin
            @(posedge clk);
            #2;
            waited++;
        end
        assert (!queue_full) else begin
            errors++;
            $display("queue stayed full, word at pc %h was not pushed", f.pc);
        end
        if (!queue_full) begin
            inst_valid = 1'b1;
            fetch      = f;
            exp_q.push_back(expect_decode(f));
            @(posedge clk);
            #2;
            inst_valid = 1'b0;
        end
    endtask

    task automatic feed();
        while (stim_q.size() > 0) begin
            push_word(stim_q.pop_front());
        end
    endtask

    task automatic collect(input string name, input int count, input bit stall_on);
        int                got;
        int                idle;
        idu_pkg::dec_pkt_t want;
        got  = 0;
        idle = 0;
        while (got < count) begin
            @(posedge clk);
            #1;
            if (dec_valid) begin
                assert (exp_q.size() > 0) else begin
                    errors++;
                    $display("%s: dec_valid with no word outstanding", name);
                end
                want = (exp_q.size() > 0) ? exp_q.pop_front() : '0;
                check_value(name, "dec", want, dec);
                got++;
                idle = 0;
            end else begin
                idle++;
            end
            assert (idle < WAIT_LIMIT) else begin
                errors++;
                $display("%s: no decoded instruction arrived", name);
            end
            if (idle >= WAIT_LIMIT) begin
                exp_q.delete();
                got = count;
            end
            #1;
            dec_stall = stall_on ? (next_random() % 100 < 40) : 1'b0;
        end
    endtask

    task automatic run_words(input string name, input bit stall_on);
        int total;
        total = exp_q.size() + stim_q.size();
        fork
            feed();
            collect(name, total, stall_on);
        join
        dec_stall = 1'b0;
        for (int i = 0; i < 2; i++) begin
            @(posedge clk);
            #1;
            check_value(name, "trailing dec_valid", 1'b0, dec_valid);
            #1;
        end
    endtask

    task automatic test_reset_latency();
        check_value("reset", "dec_valid", 1'b0, dec_valid);
        check_value("reset", "queue_full", 1'b0, queue_full);
        queue_word(idu_pkg::OP_REG, 3'b000, 7'h00);
        inst_valid = 1'b1;
        fetch      = stim_q.pop_front();
        exp_q.push_back(expect_decode(fetch));
        // queue write at the first edge and output register at the second
        @(posedge clk);
        #1;
        check_value("latency", "dec_valid after first edge", 1'b0, dec_valid);
        #1;
        inst_valid = 1'b0;
        @(posedge clk);
        #1;
        check_value("latency", "dec_valid after second edge", 1'b1, dec_valid);
        check_value("latency", "dec", exp_q.pop_front(), dec);
        #1;
        @(posedge clk);
        #1;
        check_value("latency", "dec_valid after third edge", 1'b0, dec_valid);
        #1;
    endtask

    task automatic test_arith();
        for (int i = 0; i < 8; i++) begin
            queue_word(idu_pkg::OP_REG, 3'(i), 7'h00);
            queue_word(idu_pkg::OP_IMM, 3'(i), (i == 5) ? 7'h00 : 7'(next_random()));
        end
        queue_word(idu_pkg::OP_REG, 3'b000, 7'h20);
        queue_word(idu_pkg::OP_REG, 3'b101, 7'h20);
        queue_word(idu_pkg::OP_IMM, 3'b101, 7'h20);
        // addi must ignore funct7 bit 5
        queue_word(idu_pkg::OP_IMM, 3'b000, 7'h20);
        queue_word(idu_pkg::OP_IMM, 3'b000, 7'h7f);
        run_words("arith", 1'b0);
    endtask

    task automatic test_branch();
        for (int i = 0; i < 8; i++) begin
            queue_word(idu_pkg::OP_BRANCH, 3'(i), 7'(next_random()));
            queue_word(idu_pkg::OP_BRANCH, 3'(i), 7'(next_random()) | 7'h40);
        end
        run_words("branch", 1'b0);
    endtask

    task automatic test_mem();
        for (int i = 0; i < 6; i++) begin
            queue_word(idu_pkg::OP_LOAD, 3'(i), 7'(next_random()));
            queue_word(idu_pkg::OP_LOAD, 3'(i), 7'h7f);
        end
        for (int i = 0; i < 3; i++) begin
            queue_word(idu_pkg::OP_STORE, 3'(i), 7'(next_random()) & 7'h3f);
            queue_word(idu_pkg::OP_STORE, 3'(i), 7'(next_random()) | 7'h40);
        end
        run_words("mem", 1'b0);
    endtask

    task automatic test_upper_jump();
        for (int i = 0; i < 2; i++) begin
            queue_word(idu_pkg::OP_LUI, 3'(next_random()), 7'(next_random()));
            queue_word(idu_pkg::OP_AUIPC, 3'(next_random()), 7'(next_random()));
            queue_word(idu_pkg::OP_JAL, 3'(next_random()), 7'(next_random()));
            queue_word(idu_pkg::OP_JALR, 3'b000, 7'(next_random()));
            queue_word(idu_pkg::OP_SYSTEM, 3'(next_random()), 7'(next_random()));
        end
        queue_word(7'b0000000, 3'b000, 7'h00);
        queue_word(7'b0001111, 3'b001, 7'h40);
        queue_word(7'b1111111, 3'b111, 7'h7f);
        run_words("upper_jump", 1'b0);
    endtask

    task automatic test_burst();
        logic [6:0]  ops [0:9];
        logic [31:0] r;
        ops = '{idu_pkg::OP_LUI, idu_pkg::OP_AUIPC, idu_pkg::OP_JAL, idu_pkg::OP_JALR,
                idu_pkg::OP_BRANCH, idu_pkg::OP_LOAD, idu_pkg::OP_STORE, idu_pkg::OP_IMM,
                idu_pkg::OP_REG, idu_pkg::OP_SYSTEM};
        for (int i = 0; i < 40; i++) begin
            r = next_random();
            stim_q.push_back('{pc: 32'h2000 + 32'(4 * i),
                               inst: {r[31:7], ops[next_random() % 10]}});
        end
        // hold the stage so that the queue fills up
        dec_stall = 1'b1;
        for (int i = 0; i < 4; i++) begin
            push_word(stim_q.pop_front());
        end
        check_value("burst", "queue_full", 1'b1, queue_full);
        check_value("burst", "dec_valid while stalled", 1'b0, dec_valid);
        run_words("burst", 1'b1);
    endtask

    initial begin
        errors     = 0;
        rng_state  = 32'd79634;
        arst_n     = 1'b0;
        inst_valid = 1'b0;
        fetch      = '0;
        dec_stall  = 1'b0;
        repeat (2) @(posedge clk);
        #2;
        arst_n = 1'b1;
        test_reset_latency();
        test_arith();
        test_branch();
        test_mem();
        test_upper_jump();
        test_burst();
        $display("checks done, errors: %0d", errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: sim.f
verilog/idu_pkg.sv
verilog/mux_def.sv
verilog/inst_type_dec.sv
verilog/imm_gen.sv
verilog/ctrl.sv
verilog/inst_queue.sv
verilog/idu.sv
test/idu_tb.sv

// File: Bender.yml
package:
  name: idu

sources:
  - verilog/idu_pkg.sv
  - verilog/mux_def.sv
  - verilog/inst_type_dec.sv
  - verilog/imm_gen.sv
  - verilog/ctrl.sv
  - verilog/inst_queue.sv
  - verilog/idu.sv
  - target: test
    files:
      - test/idu_tb.sv
